//--- vlog.f
+incdir+rtl
rtl/gcd_pkg.sv
rtl/gcd_engine.sv
rtl/gcd_dispatch.sv
rtl/gcd_collect.sv
rtl/gcd_top.sv
sim/gcd_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the GCD testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module gcd_tb -o gcd_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/gcd_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "Done: no errors"; then
  exit 0
fi
echo "simulation did not report success"
exit 1

//--- sim/gcd_tb.sv
// self-checking testbench for the multi-engine GCD unit
// table entries one at a time, then streamed requests with random response stalls
`default_nettype none
`timescale 1ns/10ps

`include "gcd_macros.svh"

module gcd_tb;

  localparam int TABLE_LEN      = 10;
  localparam int RAND_LEN       = 24;
  localparam int TIMEOUT_CYCLES = 100000;

  logic                  clk;
  logic                  reset;
  logic                  req_valid;
  logic                  req_ready;
  gcd_pkg::gcd_operand_t req_a;
  gcd_pkg::gcd_operand_t req_b;
  logic                  resp_valid;
  logic                  resp_ready;
  gcd_pkg::gcd_operand_t resp_result;

  // operand pairs and their gcd
  gcd_pkg::gcd_operand_t tab_a [0:TABLE_LEN-1] = '{16'd15, 16'd22, 16'd36, 16'd36, 16'd0,
                                                  16'd9, 16'd0, 16'd65535, 16'd12, 16'd1};
  gcd_pkg::gcd_operand_t tab_b [0:TABLE_LEN-1] = '{16'd10, 16'd10, 16'd18, 16'd21, 16'd7,
                                                  16'd0, 16'd0, 16'd1, 16'd12, 16'd1};
  gcd_pkg::gcd_operand_t tab_exp [0:TABLE_LEN-1] = '{16'd5, 16'd2, 16'd18, 16'd3, 16'd7,
                                                    16'd9, 16'd0, 16'd1, 16'd12, 16'd1};

  // pending stimulus, and expected results of accepted requests
  gcd_pkg::gcd_operand_t send_a [$];
  gcd_pkg::gcd_operand_t send_b [$];
  gcd_pkg::gcd_operand_t send_exp [$];
  gcd_pkg::gcd_operand_t exp_q [$];

  int errors;
  int seed;
  bit aborted;
  bit saw_ready_low;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  gcd_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_result (resp_result)
  );

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // reference model, Euclid by remainder
  function automatic gcd_pkg::gcd_operand_t euclid_gcd(input gcd_pkg::gcd_operand_t a,
                                                      input gcd_pkg::gcd_operand_t b);
    gcd_pkg::gcd_operand_t x;
    gcd_pkg::gcd_operand_t y;
    gcd_pkg::gcd_operand_t r;
    x = a;
    y = b;
    while (y != 0) begin
      r = x % y;
      x = y;
      y = r;
    end
    return x;
  endfunction

  // 10-bit operands keep the subtract loop short
  function automatic gcd_pkg::gcd_operand_t rand_operand();
    logic [31:0] r;
    r = $random(seed);
    return r[`GCD_W-1:0] & 16'h03ff;
  endfunction

  task automatic queue_random(input int count);
    gcd_pkg::gcd_operand_t a;
    gcd_pkg::gcd_operand_t b;
    for (int i = 0; i < count; i++) begin
      a = rand_operand();
      b = rand_operand();
      send_a.push_back(a);
      send_b.push_back(b);
      send_exp.push_back(euclid_gcd(a, b));
    end
  endtask

  // request side, back to back, valid and data held until ready
  task automatic send_stream();
    int wait_cycles;
    while (send_a.size() > 0 && !aborted) begin
      @(negedge clk);
      req_valid = 1'b1;
      req_a     = send_a[0];
      req_b     = send_b[0];
      wait_cycles = 0;
      // ready only follows engine state, so it is settled at the falling edge
      while (!req_ready && !aborted && wait_cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!aborted && !req_ready) begin
        errors++;
        $display("timeout: req_ready never came back for a held request");
        aborted = 1'b1;
      end else if (!aborted) begin
        // transfer happens on the coming rising edge
        exp_q.push_back(send_exp.pop_front());
        void'(send_a.pop_front());
        void'(send_b.pop_front());
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // response side, optional random stalls with a long one first
  task automatic receive_stream(input int total, input bit with_hold);
    int received;
    int idle_cycles;
    int hold_left;
    bit held;
    gcd_pkg::gcd_operand_t held_value;
    received    = 0;
    idle_cycles = 0;
    hold_left   = with_hold ? 40 : 0;
    held        = 1'b0;
    held_value  = '0;
    while (received < total && !aborted) begin
      @(negedge clk);
      resp_ready = (hold_left == 0);
      if (hold_left > 0) begin
        hold_left--;
      end
      // a stalled response keeps valid and data
      if (held) begin
        check_value(32'(resp_valid), 32'd1, "resp_valid dropped before transfer");
        check_value(32'(resp_result), 32'(held_value), "resp_result changed while stalled");
      end
      held       = resp_valid && !resp_ready;
      held_value = resp_result;
      // issue side stalls once results back up
      if (held && !req_ready) begin
        saw_ready_low = 1'b1;
      end
      idle_cycles++;
      if (resp_valid && resp_ready) begin
        idle_cycles = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response seen with no request outstanding");
          aborted = 1'b1;
        end else begin
          check_value(32'(resp_result), 32'(exp_q.pop_front()), "response value");
          received++;
          if (with_hold) begin
            hold_left = {$random(seed)} % 24;
          end
        end
      end else if (idle_cycles >= TIMEOUT_CYCLES) begin
        errors++;
        $display("timeout: expected response %0d of %0d never arrived", received + 1, total);
        aborted = 1'b1;
      end
    end
    // nothing extra after the last response
    @(negedge clk);
    resp_ready = 1'b1;
    check_value(32'(resp_valid), 32'd0, "extra response after the last one");
    check_value(32'(exp_q.size()), 32'd0, "requests left without a response");
  endtask

  task automatic run_stream(input int total, input bit with_hold);
    fork
      send_stream();
      receive_stream(total, with_hold);
    join
  endtask

  initial begin
    errors        = 0;
    seed          = 65894;
    aborted       = 1'b0;
    saw_ready_low = 1'b0;
    reset         = 1'b1;
    req_valid     = 1'b0;
    req_a         = '0;
    req_b         = '0;
    resp_ready    = 1'b1;

    repeat (3) @(negedge clk);
    reset = 1'b0;

    // idle state after reset
    @(negedge clk);
    check_value(32'(resp_valid), 32'd0, "resp_valid after reset");
    check_value(32'(req_ready), 32'd1, "req_ready after reset");

    // each table entry on its own
    for (int i = 0; i < TABLE_LEN && !aborted; i++) begin
      send_a.push_back(tab_a[i]);
      send_b.push_back(tab_b[i]);
      send_exp.push_back(tab_exp[i]);
      run_stream(1, 1'b0);
    end

    // whole table plus random pairs, streamed
    for (int i = 0; i < TABLE_LEN; i++) begin
      send_a.push_back(tab_a[i]);
      send_b.push_back(tab_b[i]);
      send_exp.push_back(tab_exp[i]);
    end
    queue_random(RAND_LEN);
    if (!aborted) begin
      run_stream(TABLE_LEN + RAND_LEN, 1'b0);
    end

    // random stalls on the response side
    saw_ready_low = 1'b0;
    queue_random(RAND_LEN);
    if (!aborted) begin
      run_stream(RAND_LEN, 1'b1);
      check_value(32'(saw_ready_low), 32'd1, "req_ready never dropped under back-pressure");
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/gcd_top.sv
// multi-engine GCD unit top level
// valid/ready request and response channels, results in request order
`default_nettype none
`timescale 1ns/10ps

`include "gcd_macros.svh"

module gcd_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_valid,
  output logic                  req_ready,
  input  gcd_pkg::gcd_operand_t req_a,
  input  gcd_pkg::gcd_operand_t req_b,
  output logic                  resp_valid,
  input  wire                   resp_ready,
  output gcd_pkg::gcd_operand_t resp_result
);

  // per-engine handshake masks
  gcd_pkg::gcd_engine_mask_t eng_req_valid;
  gcd_pkg::gcd_engine_mask_t eng_req_ready;
  gcd_pkg::gcd_engine_mask_t eng_resp_valid;
  gcd_pkg::gcd_engine_mask_t eng_resp_ready;

  // one result word per engine
  gcd_pkg::gcd_operand_t     eng_resp_result [0:`GCD_ENGINES-1];

  //--------------------------------------------------
  // request side
  //--------------------------------------------------

  gcd_dispatch u_dispatch (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .eng_req_valid (eng_req_valid),
    .eng_req_ready (eng_req_ready)
  );

  //--------------------------------------------------
  // engines
  //--------------------------------------------------

  // operands broadcast, only the selected engine loads them
  for (genvar i = 0; i < `GCD_ENGINES; i++) begin : g_engine
    gcd_engine u_engine (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (eng_req_valid[i]),
      .req_ready   (eng_req_ready[i]),
      .req_a       (req_a),
      .req_b       (req_b),
      .resp_valid  (eng_resp_valid[i]),
      .resp_ready  (eng_resp_ready[i]),
      .resp_result (eng_resp_result[i])
    );
  end

  //--------------------------------------------------
  // response side
  //--------------------------------------------------

  gcd_collect u_collect (
    .clk             (clk),
    .reset           (reset),
    .eng_resp_valid  (eng_resp_valid),
    .eng_resp_ready  (eng_resp_ready),
    .eng_resp_result (eng_resp_result),
    .resp_valid      (resp_valid),
    .resp_ready      (resp_ready),
    .resp_result     (resp_result)
  );

endmodule

`default_nettype wire

//--- rtl/gcd_collect.sv
// round-robin result collector
// drains engines in issue order so results leave in request order
`default_nettype none
`timescale 1ns/10ps

`include "gcd_macros.svh"

module gcd_collect (
  input  wire                       clk,
  input  wire                       reset,
  input  gcd_pkg::gcd_engine_mask_t eng_resp_valid,
  output gcd_pkg::gcd_engine_mask_t eng_resp_ready,
  input  gcd_pkg::gcd_operand_t     eng_resp_result [0:`GCD_ENGINES-1],
  output logic                      resp_valid,
  input  wire                       resp_ready,
  output gcd_pkg::gcd_operand_t     resp_result
);

  // last engine index for the wrap
  localparam gcd_pkg::gcd_engine_sel_t LAST_SEL =
    gcd_pkg::gcd_engine_sel_t'(`GCD_ENGINES - 1);

  gcd_pkg::gcd_engine_sel_t drain_ptr;
  logic                     resp_xfer;

  //--------------------------------------------------
  // output select
  //--------------------------------------------------

  // valid and data from the engine at the pointer
  assign resp_valid  = eng_resp_valid[drain_ptr];
  assign resp_result = eng_resp_result[drain_ptr];

  // other engines hold in DONE until their turn
  always_comb begin
    eng_resp_ready            = '0;
    eng_resp_ready[drain_ptr] = resp_ready;
  end

  assign resp_xfer = resp_valid && resp_ready;

  //--------------------------------------------------
  // drain pointer
  //--------------------------------------------------

  // follows the dispatcher's order, one step per result
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (resp_xfer) begin
      if (drain_ptr == LAST_SEL) begin
        drain_ptr <= '0;
      end else begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/gcd_dispatch.sv
// round-robin request dispatcher
// steers each incoming request to the engine at the issue pointer
`default_nettype none
`timescale 1ns/10ps

`include "gcd_macros.svh"

module gcd_dispatch (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       req_valid,
  output logic                      req_ready,
  output gcd_pkg::gcd_engine_mask_t eng_req_valid,
  input  gcd_pkg::gcd_engine_mask_t eng_req_ready
);

  // last engine index, pointer wraps after it
  localparam gcd_pkg::gcd_engine_sel_t LAST_SEL =
    gcd_pkg::gcd_engine_sel_t'(`GCD_ENGINES - 1);

  gcd_pkg::gcd_engine_sel_t issue_ptr;
  logic                     req_xfer;

  //--------------------------------------------------
  // steering
  //--------------------------------------------------

  // only the engine at the pointer sees valid
  always_comb begin
    eng_req_valid            = '0;
    eng_req_valid[issue_ptr] = req_valid;
  end

  // ready straight from the selected engine, no delay
  assign req_ready = eng_req_ready[issue_ptr];
  assign req_xfer  = req_valid && req_ready;

  //--------------------------------------------------
  // issue pointer
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (req_xfer) begin
      // next engine, wrap at the end
      if (issue_ptr == LAST_SEL) begin
        issue_ptr <= '0;
      end else begin
        issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/gcd_engine.sv
// single iterative GCD engine, subtract-and-swap algorithm
// takes one request, computes, then holds the result until it is taken
`default_nettype none
`timescale 1ns/10ps

`include "gcd_macros.svh"

module gcd_engine (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  req_valid,
  output logic                 req_ready,
  input  gcd_pkg::gcd_operand_t req_a,
  input  gcd_pkg::gcd_operand_t req_b,
  output logic                 resp_valid,
  input  wire                  resp_ready,
  output gcd_pkg::gcd_operand_t resp_result
);

  gcd_pkg::gcd_state_e   state;
  gcd_pkg::gcd_state_e   state_next;

  // operand registers
  gcd_pkg::gcd_operand_t a_reg;
  gcd_pkg::gcd_operand_t b_reg;

  // datapath status
  logic                  a_lt_b;
  logic                  b_zero;
  gcd_pkg::gcd_operand_t a_minus_b;

  logic                  req_xfer;
  logic                  resp_xfer;

  //--------------------------------------------------
  // control
  //--------------------------------------------------

  // only idle engines take work
  assign req_ready  = (state == gcd_pkg::IDLE);
  // result held while in DONE
  assign resp_valid = (state == gcd_pkg::DONE);

  assign req_xfer  = req_valid && req_ready;
  assign resp_xfer = resp_valid && resp_ready;

  always_comb begin
    state_next = state;
    case (state)
      gcd_pkg::IDLE: begin
        if (req_xfer) begin
          state_next = gcd_pkg::CALC;
        end
      end
      gcd_pkg::CALC: begin
        // finished once a >= b and b hit zero
        if (!a_lt_b && b_zero) begin
          state_next = gcd_pkg::DONE;
        end
      end
      gcd_pkg::DONE: begin
        if (resp_xfer) begin
          state_next = gcd_pkg::IDLE;
        end
      end
      default: begin
        state_next = gcd_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= gcd_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  //--------------------------------------------------
  // datapath
  //--------------------------------------------------

  // compare and subtract on the current operands
  assign a_lt_b    = (a_reg < b_reg);
  assign b_zero    = (b_reg == '0);
  assign a_minus_b = a_reg - b_reg;

  always_ff @(posedge clk) begin
    case (state)
      gcd_pkg::IDLE: begin
        // load new operands on accept
        if (req_xfer) begin
          a_reg <= req_a;
          b_reg <= req_b;
        end
      end
      gcd_pkg::CALC: begin
        if (a_lt_b) begin
          // swap so that a >= b
          a_reg <= b_reg;
          b_reg <= a_reg;
        end else if (!b_zero) begin
          a_reg <= a_minus_b;
        end
      end
      default: begin
        // DONE keeps both operands
      end
    endcase
  end

  // a holds the gcd once in DONE
  assign resp_result = a_reg;

endmodule

`default_nettype wire

//--- rtl/gcd_pkg.sv
// shared types for the GCD unit
// modules refer to these by gcd_pkg:: scoped names
`default_nettype none

`include "gcd_macros.svh"

package gcd_pkg;

  // one operand or result word
  typedef logic [`GCD_W-1:0] gcd_operand_t;

  // one bit per engine, for valid and ready masks
  typedef logic [`GCD_ENGINES-1:0] gcd_engine_mask_t;

  // round-robin engine pointer
  typedef logic [`GCD_SEL_W-1:0] gcd_engine_sel_t;

  // engine FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } gcd_state_e;

endpackage

`default_nettype wire

//--- rtl/gcd_macros.svh
// width and engine count defines for the multi-engine GCD unit
// included by the package and by every RTL file
`ifndef GCD_MACROS_SVH
`define GCD_MACROS_SVH

// operand and result width
`define GCD_W       16
// engines working in parallel, 2 or more
`define GCD_ENGINES 4
// engine index width, must cover GCD_ENGINES
`define GCD_SEL_W   2

`endif
